//--- adc_top.f
adc_pkg.sv
adc_capture.sv
adc_pn_check.sv
adc_pn_run_counter.sv
adc_pn_sync_fsm.sv
adc_pack.sv
up_wb_regs.sv
adc_top.sv
tb_adc_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_adc_top
FILELIST  = adc_top.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- tb_adc_top.sv
// ****************************************
// adc capture core testbench
// register, packing, pn and sticky status checks
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module tb_adc_top;

  logic        adc_clk;
  logic        reset;
  logic [11:0] adc_data;
  logic        adc_or;
  logic        dma_valid;
  logic [63:0] dma_data;
  logic        dma_dovf;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_wdata;
  logic [31:0] wb_rdata;
  logic        wb_ack;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_mark = 0;
  int          beats_exp = 0;
  logic        src_lfsr = 1'b0;
  logic        corrupt = 1'b0;
  logic [11:0] lfsr = 12'h5a3;
  logic [31:0] rd;

  // model state for the packer
  adc_pkg::dma_beat_u exp_q[$];
  adc_pkg::dma_beat_u pend_beat;
  adc_pkg::dma_beat_u act_beat;
  logic        m_en;
  logic        m_fs;
  logic        m_ack;
  logic        m_pend;
  logic        fs_before;
  logic        accept;
  int          m_cnt;
  logic [11:0] grp_s [4];
  logic [3:0]  grp_f;

  adc_top UUT (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .adc_data  (adc_data),
    .adc_or    (adc_or),
    .dma_valid (dma_valid),
    .dma_data  (dma_data),
    .dma_dovf  (dma_dovf),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_wdata  (wb_wdata),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  // ****************************************
  // reference model
  // ****************************************
  function automatic logic [11:0] next_pn(input logic [11:0] s);
    return {s[10:0], s[11] ^ s[10] ^ s[9] ^ s[3]};
  endfunction

  function automatic logic [15:0] format_lane(input logic [11:0] s, input logic sgn);
    logic [11:0] t;
    t = s ^ 12'h800;
    if (sgn) return {{4{t[11]}}, t};
    return {4'h0, s};
  endfunction

  function automatic adc_pkg::dma_beat_u expected_beat(input logic [11:0] s0, s1, s2, s3,
                                                       input logic [3:0] fs);
    adc_pkg::dma_beat_u b;
    b.lane[0] = format_lane(s0, fs[0]);
    b.lane[1] = format_lane(s1, fs[1]);
    b.lane[2] = format_lane(s2, fs[2]);
    b.lane[3] = format_lane(s3, fs[3]);
    return b;
  endfunction

  task automatic check_beat(input string name, input adc_pkg::dma_beat_u exp_b,
                            input adc_pkg::dma_beat_u act_b);
    if (exp_b.raw !== act_b.raw) begin
      $display("Fail %s expected %h actual %h", name, exp_b.raw, act_b.raw);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s expected %h actual %h", name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_mark) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, errors - test_mark);
      tests_failed++;
    end
    test_mark = errors;
  endtask

  // ****************************************
  // wishbone master
  // ****************************************
  // ack is due on the first clock after the request
  task automatic wait_for_ack();
    int waits;
    @(posedge adc_clk);
    #1;
    waits = 1;
    while (!wb_ack) begin
      @(posedge adc_clk);
      #1;
      waits++;
    end
    if (waits != 1) begin
      $display("wishbone ack came %0d cycles after the request instead of one", waits);
      errors++;
    end
  endtask

  // drop the request and see ack fall after its single cycle
  task automatic release_bus();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(posedge adc_clk);
    #1;
    if (wb_ack) begin
      $display("wishbone ack stayed high for more than one cycle");
      errors++;
    end
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_wdata = data;
    wait_for_ack();
    release_bus();
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    wait_for_ack();
    data = wb_rdata;
    release_bus();
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #1;
  endtask

  // sample source switches between random data and the pn sequence
  always @(posedge adc_clk) begin
    #1;
    if (src_lfsr) begin
      lfsr = next_pn(lfsr);
      adc_data = corrupt ? (lfsr ^ 12'h004) : lfsr;
      corrupt = 1'b0;
    end else begin
      adc_data = 12'($urandom);
    end
  end

  // beat monitor and packer model
  always @(posedge adc_clk) begin
    if (reset) begin
      m_en = 1'b0;
      m_fs = 1'b0;
      m_ack = 1'b0;
      m_pend = 1'b0;
      m_cnt = 0;
      exp_q.delete();
    end else begin
      if (dma_valid) begin
        act_beat.raw = dma_data;
        if (exp_q.size() == 0) begin
          $display("dma beat %h arrived with no beat expected", dma_data);
          errors++;
        end else begin
          check_beat("dma beat", exp_q.pop_front(), act_beat);
        end
      end
      fs_before = m_fs;
      accept = wb_cyc && wb_stb && !m_ack;
      m_ack = accept;
      if (accept && wb_we && wb_adr == adc_pkg::reg_control) begin
        m_en = wb_wdata[0];
        m_fs = wb_wdata[1];
      end
      // a finished beat only leaves while still enabled
      if (m_pend && m_en) begin
        exp_q.push_back(pend_beat);
        beats_exp++;
      end
      m_pend = 1'b0;
      if (m_en) begin
        grp_s[m_cnt] = adc_data;
        grp_f[m_cnt] = fs_before;
        if (m_cnt == 3) begin
          pend_beat = expected_beat(grp_s[0], grp_s[1], grp_s[2], grp_s[3], grp_f);
          m_pend = 1'b1;
          m_cnt = 0;
        end else begin
          m_cnt++;
        end
      end else begin
        m_cnt = 0;
      end
    end
  end

  // watchdog well beyond the few hundred cycles the tests need
  initial begin
    repeat (4000) @(posedge adc_clk);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'hf370_00df));
    reset = 1'b1;
    adc_data = '0;
    adc_or = 1'b0;
    dma_dovf = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdata = '0;
    wait_cycles(5);
    reset = 1'b0;

    // reset values and control readback
    wb_read(adc_pkg::reg_version, rd);
    check_reg("version", adc_pkg::core_version, rd);
    wb_read(adc_pkg::reg_control, rd);
    check_reg("control after reset", 32'h0, rd);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status after reset", 32'h1, rd);
    wb_write(adc_pkg::reg_control, 32'h2);
    wb_read(adc_pkg::reg_control, rd);
    check_reg("control readback", 32'h2, rd);
    end_test("reset_and_control");

    // unsigned packing
    wb_write(adc_pkg::reg_beat_count, 32'h0);
    beats_exp = 0;
    wb_write(adc_pkg::reg_control, 32'h1);
    wait_cycles(62);
    wb_write(adc_pkg::reg_control, 32'h0);
    wait_cycles(6);
    wb_read(adc_pkg::reg_beat_count, rd);
    check_reg("beat count unsigned", 32'(beats_exp), rd);
    check_reg("beats left unsigned", 32'h0, 32'(exp_q.size()));
    end_test("unsigned_packing");

    // signed packing and beat count clear
    wb_write(adc_pkg::reg_control, 32'h3);
    wait_cycles(62);
    wb_write(adc_pkg::reg_control, 32'h2);
    wait_cycles(6);
    wb_read(adc_pkg::reg_beat_count, rd);
    check_reg("beat count signed", 32'(beats_exp), rd);
    wb_write(adc_pkg::reg_beat_count, 32'h0);
    beats_exp = 0;
    wb_read(adc_pkg::reg_beat_count, rd);
    check_reg("beat count cleared", 32'h0, rd);
    end_test("signed_packing");

    // pn lock, single error, loss of sync
    src_lfsr = 1'b1;
    wait_cycles(40);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status locked", 32'h0, rd);
    corrupt = 1'b1;
    wait_cycles(6);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status pn error", 32'h2, rd);
    wb_write(adc_pkg::reg_status, 32'h2);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status pn error cleared", 32'h0, rd);
    src_lfsr = 1'b0;
    wait_cycles(24);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status lock lost", 32'h3, rd);
    wb_write(adc_pkg::reg_status, 32'h2);
    end_test("pn_lock_and_error");

    // over-range and dma overflow sticky bits
    adc_or = 1'b1;
    dma_dovf = 1'b1;
    wait_cycles(1);
    adc_or = 1'b0;
    dma_dovf = 1'b0;
    wait_cycles(4);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status sticky set", 32'hd, rd);
    wait_cycles(4);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status sticky held", 32'hd, rd);
    wb_write(adc_pkg::reg_status, 32'hc);
    wb_read(adc_pkg::reg_status, rd);
    check_reg("status sticky cleared", 32'h1, rd);
    end_test("overrange_and_overflow");

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- adc_top.sv
// ****************************************
// adc capture core top level
// capture, pn monitor, dma packer, registers
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module adc_top (
  input  wire                               adc_clk,
  input  wire                               reset,

  // sample input
  input  wire  [adc_pkg::sample_width-1:0]  adc_data,
  input  wire                               adc_or,

  // dma stream
  output logic                              dma_valid,
  output logic [adc_pkg::dma_width-1:0]     dma_data,
  input  wire                               dma_dovf,

  // wishbone register port
  input  wire                               wb_cyc,
  input  wire                               wb_stb,
  input  wire                               wb_we,
  input  wire  [adc_pkg::wb_addr_width-1:0] wb_adr,
  input  wire  [31:0]                       wb_wdata,
  output logic [31:0]                       wb_rdata,
  output logic                              wb_ack
);

  logic [adc_pkg::sample_width-1:0] sample_raw;
  logic [adc_pkg::lane_width-1:0]   sample_fmt;
  logic                             sample_or;
  logic                             sample_valid;
  logic                             pn_match;
  logic                             pn_check_valid;
  logic                             lock_reached;
  logic                             loss_reached;
  logic                             pn_oos;
  logic                             pn_err_event;
  logic                             core_enable;
  logic                             format_signed;
  logic                             beat_count_clear;
  logic [31:0]                      beat_count;
  adc_pkg::dma_beat_u               dma_beat;

  assign dma_data = dma_beat.raw;

  adc_capture i_capture (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .adc_data      (adc_data),
    .adc_or        (adc_or),
    .format_signed (format_signed),
    .sample_raw    (sample_raw),
    .sample_fmt    (sample_fmt),
    .sample_or     (sample_or),
    .sample_valid  (sample_valid)
  );

  // pn monitor chain
  adc_pn_check i_pn_check (
    .adc_clk        (adc_clk),
    .reset          (reset),
    .sample_raw     (sample_raw),
    .sample_valid   (sample_valid),
    .pn_match       (pn_match),
    .pn_check_valid (pn_check_valid)
  );

  adc_pn_run_counter i_pn_run_counter (
    .adc_clk        (adc_clk),
    .reset          (reset),
    .pn_check_valid (pn_check_valid),
    .pn_match       (pn_match),
    .lock_reached   (lock_reached),
    .loss_reached   (loss_reached)
  );

  adc_pn_sync_fsm i_pn_sync_fsm (
    .adc_clk        (adc_clk),
    .reset          (reset),
    .pn_check_valid (pn_check_valid),
    .pn_match       (pn_match),
    .lock_reached   (lock_reached),
    .loss_reached   (loss_reached),
    .pn_oos         (pn_oos),
    .pn_err_event   (pn_err_event)
  );

  adc_pack i_pack (
    .adc_clk          (adc_clk),
    .reset            (reset),
    .enable           (core_enable),
    .sample_fmt       (sample_fmt),
    .sample_valid     (sample_valid),
    .beat_count_clear (beat_count_clear),
    .dma_valid        (dma_valid),
    .dma_data         (dma_beat),
    .beat_count       (beat_count)
  );

  up_wb_regs i_regs (
    .adc_clk          (adc_clk),
    .reset            (reset),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_wdata         (wb_wdata),
    .wb_rdata         (wb_rdata),
    .wb_ack           (wb_ack),
    .pn_oos           (pn_oos),
    .pn_err_event     (pn_err_event),
    .sample_or        (sample_or),
    .dma_dovf         (dma_dovf),
    .beat_count       (beat_count),
    .core_enable      (core_enable),
    .format_signed    (format_signed),
    .beat_count_clear (beat_count_clear)
  );

endmodule

`default_nettype wire

//--- up_wb_regs.sv
// ****************************************
// wishbone register bank
// control word, sticky status and read mux
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module up_wb_regs (
  input  wire                               adc_clk,
  input  wire                               reset,
  input  wire                               wb_cyc,
  input  wire                               wb_stb,
  input  wire                               wb_we,
  input  wire  [adc_pkg::wb_addr_width-1:0] wb_adr,
  input  wire  [31:0]                       wb_wdata,
  output logic [31:0]                       wb_rdata,
  output logic                              wb_ack,
  input  wire                               pn_oos,
  input  wire                               pn_err_event,
  input  wire                               sample_or,
  input  wire                               dma_dovf,
  input  wire  [31:0]                       beat_count,
  output logic                              core_enable,
  output logic                              format_signed,
  output logic                              beat_count_clear
);

  logic        wb_accept;
  logic        wr_control;
  logic        wr_status;
  logic        sticky_pn_err;
  logic        sticky_or;
  logic        sticky_dovf;
  logic [31:0] control_word;
  logic [31:0] status_word;
  logic [31:0] read_word;

  // accept once per cycle, ack follows on the next clock
  assign wb_accept  = wb_cyc & wb_stb & ~wb_ack;
  assign wr_control = wb_accept & wb_we & (wb_adr == adc_pkg::reg_control);
  assign wr_status  = wb_accept & wb_we & (wb_adr == adc_pkg::reg_status);

  assign beat_count_clear = wb_accept & wb_we & (wb_adr == adc_pkg::reg_beat_count);

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_accept;
    end
  end

  // ****************************************
  // control word
  // ****************************************
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      core_enable   <= 1'b0;
      format_signed <= 1'b0;
    end else if (wr_control) begin
      core_enable   <= wb_wdata[adc_pkg::ctrl_enable_bit];
      format_signed <= wb_wdata[adc_pkg::ctrl_signed_bit];
    end
  end

  // ****************************************
  // sticky status, write one to clear
  // ****************************************
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      sticky_pn_err <= 1'b0;
      sticky_or     <= 1'b0;
      sticky_dovf   <= 1'b0;
    end else begin
      // a new event wins over a clear in the same cycle
      if (pn_err_event) begin
        sticky_pn_err <= 1'b1;
      end else if (wr_status && wb_wdata[adc_pkg::stat_pn_err_bit]) begin
        sticky_pn_err <= 1'b0;
      end
      if (sample_or) begin
        sticky_or <= 1'b1;
      end else if (wr_status && wb_wdata[adc_pkg::stat_or_bit]) begin
        sticky_or <= 1'b0;
      end
      if (dma_dovf) begin
        sticky_dovf <= 1'b1;
      end else if (wr_status && wb_wdata[adc_pkg::stat_dovf_bit]) begin
        sticky_dovf <= 1'b0;
      end
    end
  end

  // read mux
  always_comb begin
    control_word = '0;
    control_word[adc_pkg::ctrl_enable_bit] = core_enable;
    control_word[adc_pkg::ctrl_signed_bit] = format_signed;

    status_word = '0;
    status_word[adc_pkg::stat_oos_bit]    = pn_oos;
    status_word[adc_pkg::stat_pn_err_bit] = sticky_pn_err;
    status_word[adc_pkg::stat_or_bit]     = sticky_or;
    status_word[adc_pkg::stat_dovf_bit]   = sticky_dovf;

    case (wb_adr)
      adc_pkg::reg_version:    read_word = adc_pkg::core_version;
      adc_pkg::reg_control:    read_word = control_word;
      adc_pkg::reg_status:     read_word = status_word;
      adc_pkg::reg_beat_count: read_word = beat_count;
      default:                 read_word = '0;
    endcase
  end

  // read data valid alongside ack
  always_ff @(posedge adc_clk) begin
    if (wb_accept) begin
      wb_rdata <= read_word;
    end
  end

endmodule

`default_nettype wire

//--- adc_pack.sv
// ****************************************
// dma beat packer
// four samples per 64-bit beat, counts beats
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module adc_pack (
  input  wire                             adc_clk,
  input  wire                             reset,
  input  wire                             enable,
  input  wire  [adc_pkg::lane_width-1:0]  sample_fmt,
  input  wire                             sample_valid,
  input  wire                             beat_count_clear,
  output logic                            dma_valid,
  output adc_pkg::dma_beat_u              dma_data,
  output logic [31:0]                     beat_count
);

  adc_pkg::dma_beat_u                   beat_fill;
  logic [adc_pkg::lane_idx_width-1:0]   lane_idx;
  logic                                 beat_done;

  // lane fill, lane 0 is the oldest sample
  always_ff @(posedge adc_clk) begin
    if (enable && sample_valid) begin
      beat_fill.lane[lane_idx] <= sample_fmt;
    end
    if (beat_done) begin
      dma_data <= beat_fill;
    end
  end

  // ****************************************
  // lane index and beat strobe
  // ****************************************
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      lane_idx  <= '0;
      beat_done <= 1'b0;
      dma_valid <= 1'b0;
    end else begin
      dma_valid <= beat_done & enable;
      beat_done <= 1'b0;
      if (!enable) begin
        // held at lane 0 so a new enable starts a fresh beat
        lane_idx <= '0;
      end else if (sample_valid) begin
        lane_idx  <= lane_idx + 1'b1;
        beat_done <= (lane_idx == adc_pkg::last_lane);
      end
    end
  end

  // beat counter, cleared from the register bank
  always_ff @(posedge adc_clk) begin
    if (reset || beat_count_clear) begin
      beat_count <= '0;
    end else if (dma_valid) begin
      beat_count <= beat_count + 32'd1;
    end
  end

endmodule

`default_nettype wire

//--- adc_pn_sync_fsm.sv
// ****************************************
// pn sync state machine
// tracks lock and reports errors while locked
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module adc_pn_sync_fsm (
  input  wire  adc_clk,
  input  wire  reset,
  input  wire  pn_check_valid,
  input  wire  pn_match,
  input  wire  lock_reached,
  input  wire  loss_reached,
  output logic pn_oos,
  output logic pn_err_event
);

  logic pn_state;

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      pn_state     <= adc_pkg::pn_state_oos;
      pn_err_event <= 1'b0;
    end else begin
      pn_err_event <= 1'b0;
      case (pn_state)
        adc_pkg::pn_state_oos: begin
          // no error events until the stream has locked once
          if (lock_reached) begin
            pn_state <= adc_pkg::pn_state_sync;
          end
        end
        adc_pkg::pn_state_sync: begin
          if (pn_check_valid && !pn_match) begin
            pn_err_event <= 1'b1;
          end
          if (loss_reached) begin
            pn_state <= adc_pkg::pn_state_oos;
          end
        end
      endcase
    end
  end

  assign pn_oos = (pn_state == adc_pkg::pn_state_oos);

endmodule

`default_nettype wire

//--- adc_pn_run_counter.sv
// ****************************************
// pn run length counter
// flags a full run of matches or mismatches
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module adc_pn_run_counter (
  input  wire  adc_clk,
  input  wire  reset,
  input  wire  pn_check_valid,
  input  wire  pn_match,
  output logic lock_reached,
  output logic loss_reached
);

  logic [adc_pkg::pn_count_width-1:0] run_count;
  logic [adc_pkg::pn_count_width-1:0] next_count;
  logic                               run_match;

  // restart on a flipped outcome and saturate at the threshold
  always_comb begin
    if (pn_match != run_match) begin
      next_count = {{(adc_pkg::pn_count_width-1){1'b0}}, 1'b1};
    end else if (run_count == adc_pkg::pn_count_max) begin
      next_count = run_count;
    end else begin
      next_count = run_count + 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      run_count <= '0;
      run_match <= 1'b0;
    end else if (pn_check_valid) begin
      run_count <= next_count;
      run_match <= pn_match;
    end
  end

  // flags come with the check that completes the run
  assign lock_reached = pn_check_valid & pn_match & (next_count == adc_pkg::pn_count_max);
  assign loss_reached = pn_check_valid & ~pn_match & (next_count == adc_pkg::pn_count_max);

endmodule

`default_nettype wire

//--- adc_pn_check.sv
// ****************************************
// pn sequence checker
// predicts each sample from the one before
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module adc_pn_check (
  input  wire                              adc_clk,
  input  wire                              reset,
  input  wire  [adc_pkg::sample_width-1:0] sample_raw,
  input  wire                              sample_valid,
  output logic                             pn_match,
  output logic                             pn_check_valid
);

  logic [adc_pkg::sample_width-1:0] prev_sample;
  logic                             prev_valid;
  logic [adc_pkg::sample_width-1:0] pn_predict;
  logic                             feedback;

  // 12-bit maximal lfsr, taps at bits 11, 10, 9 and 3
  assign feedback   = prev_sample[11] ^ prev_sample[10] ^ prev_sample[9] ^ prev_sample[3];
  assign pn_predict = {prev_sample[adc_pkg::sample_width-2:0], feedback};

  // previous sample seeds the prediction (self-synchronizing)
  always_ff @(posedge adc_clk) begin
    if (sample_valid) begin
      prev_sample <= sample_raw;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      prev_valid     <= 1'b0;
      pn_check_valid <= 1'b0;
      pn_match       <= 1'b0;
    end else begin
      pn_check_valid <= 1'b0;
      if (sample_valid) begin
        prev_valid <= 1'b1;
        // first sample has nothing to be checked against
        pn_check_valid <= prev_valid;
        pn_match       <= (sample_raw == pn_predict);
      end
    end
  end

endmodule

`default_nettype wire

//--- adc_capture.sv
// ****************************************
// adc input capture
// registers pad samples and formats each one
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module adc_capture (
  input  wire                              adc_clk,
  input  wire                              reset,
  input  wire  [adc_pkg::sample_width-1:0] adc_data,
  input  wire                              adc_or,
  input  wire                              format_signed,
  output logic [adc_pkg::sample_width-1:0] sample_raw,
  output logic [adc_pkg::lane_width-1:0]   sample_fmt,
  output logic                             sample_or,
  output logic                             sample_valid
);

  logic [adc_pkg::lane_width-1:0] fmt_next;
  logic                           msb_flip;

  // offset binary to two's complement by inverting the top bit
  assign msb_flip = ~adc_data[adc_pkg::sample_width-1];

  always_comb begin
    if (format_signed) begin
      fmt_next = {{(adc_pkg::lane_width - adc_pkg::sample_width){msb_flip}},
                  msb_flip, adc_data[adc_pkg::sample_width-2:0]};
    end else begin
      fmt_next = {{(adc_pkg::lane_width - adc_pkg::sample_width){1'b0}}, adc_data};
    end
  end

  // pad register stage
  always_ff @(posedge adc_clk) begin
    sample_raw <= adc_data;
    sample_fmt <= fmt_next;
    sample_or  <= adc_or;
  end

  // one sample per clock once out of reset
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- adc_pkg.sv
// ****************************************
// adc capture core shared definitions
// sizes, register map, pn lock and dma beat
// ****************************************

`default_nettype none

package adc_pkg;

  // sample and beat sizes
  localparam int unsigned sample_width   = 12;
  localparam int unsigned lane_width     = 16;
  localparam int unsigned lanes_per_beat = 4;
  localparam int unsigned dma_width      = 64;
  localparam int unsigned lane_idx_width = $clog2(lanes_per_beat);
  localparam logic [lane_idx_width-1:0] last_lane = lane_idx_width'(lanes_per_beat - 1);

  // ****************************************
  // register map
  // ****************************************
  localparam int unsigned wb_addr_width = 2;
  localparam logic [wb_addr_width-1:0] reg_version    = 2'd0;
  localparam logic [wb_addr_width-1:0] reg_control    = 2'd1;
  localparam logic [wb_addr_width-1:0] reg_status     = 2'd2;
  localparam logic [wb_addr_width-1:0] reg_beat_count = 2'd3;

  localparam int unsigned ctrl_enable_bit = 0;
  localparam int unsigned ctrl_signed_bit = 1;

  localparam int unsigned stat_oos_bit    = 0;
  localparam int unsigned stat_pn_err_bit = 1;
  localparam int unsigned stat_or_bit     = 2;
  localparam int unsigned stat_dovf_bit   = 3;

  localparam logic [31:0] core_version = 32'h0001_0200;

  // pn monitor, same run length to lock and to lose lock
  localparam int unsigned pn_lock_count  = 16;
  localparam int unsigned pn_count_width = $clog2(pn_lock_count + 1);
  localparam logic [pn_count_width-1:0] pn_count_max = pn_count_width'(pn_lock_count);
  localparam logic pn_state_oos  = 1'b0;
  localparam logic pn_state_sync = 1'b1;

  // one dma beat, seen as a flat word or as sample lanes
  typedef union packed {
    logic [dma_width-1:0] raw;
    logic [lanes_per_beat-1:0][lane_width-1:0] lane;
  } dma_beat_u;

endpackage

`default_nettype wire
